/* compile.f */
logic/cart_pkg.sv
logic/bsram_bus_if.sv
logic/cart_header_detect.sv
logic/cheat_code_assembler.sv
logic/bsram_clear.sv
logic/bsram_arbiter.sv
logic/backup_sync.sv
logic/cart_top.sv
tests/cart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cartridge support testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module cart_tb -Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vcart_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Result: FAILED" "$LOG_FILE"; then
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

exit 0

/* tests/cart_tb.sv */
// Self-checking testbench for cart_top, needs a simulator with timing and SVA support
`timescale 1ns/1ps

module cart_tb import cart_pkg::*; ();

	localparam int          CLK_PERIOD   = 8;
	localparam int          RESET_CYCLES = 3;
	localparam logic [15:0] LFSR_SEED    = 16'h0007;
	// x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] LFSR_TAPS    = 16'hB400;

	// LoROM image used for the save and load tests
	localparam logic [7:0]  LOROM_ROM_SIZE = 8'h0B;
	localparam logic [7:0]  LOROM_RAM_SIZE = 8'h02;
	localparam logic [23:0] LOROM_ROM_MASK = 24'h1FFFFF;
	localparam logic [23:0] LOROM_RAM_MASK = 24'h000FFF;
	localparam int          EXP_SECTORS    = int'(LOROM_RAM_MASK >> 9) + 1;

	// Four downloads, three clears, three transfers plus three console passes
	localparam int DOWNLOAD_CYCLES = 4 * 24;
	localparam int CLEAR_CYCLES    = 3 * BSRAM_BYTES;
	localparam int TRANSFER_CYCLES = 3 * EXP_SECTORS * 4 * SECTOR_WORDS + 3 * BSRAM_BYTES;
	localparam int WATCHDOG_CYCLES = 20 * (DOWNLOAD_CYCLES + CLEAR_CYCLES + TRANSFER_CYCLES);

	logic                        clk_sys;
	logic                        RESET;
	logic                        ioctl_download;
	logic [7:0]                  ioctl_index;
	logic                        ioctl_wr;
	logic [24:0]                 ioctl_addr;
	logic [15:0]                 ioctl_dout;
	header_sel_t                 header_sel;
	region_sel_t                 region_sel;
	logic                        autosave;
	logic                        osd_open;
	logic                        bk_load_req;
	logic                        bk_save_req;
	logic                        img_mounted;
	logic                        img_readonly;
	logic [63:0]                 img_size;
	logic [31:0]                 sd_lba;
	logic                        sd_rd;
	logic                        sd_wr;
	logic                        sd_ack;
	logic [SECTOR_ADDR_BITS-1:0] sd_buff_addr;
	logic [15:0]                 sd_buff_dout;
	logic                        sd_buff_wr;
	logic [15:0]                 sd_buff_din;
	logic [BSRAM_BITS-1:0]       bsram_addr;
	logic [7:0]                  bsram_d;
	logic                        bsram_ce_n;
	logic                        bsram_we_n;
	logic [7:0]                  bsram_q;
	logic [7:0]                  rom_type;
	logic [23:0]                 rom_mask;
	logic [23:0]                 ram_mask;
	logic                        pal;
	cheat_code_t                 gg_code;
	logic                        gg_strobe;
	logic                        sys_reset;
	logic                        bk_busy;
	logic                        led_user;

	logic [15:0] lfsr = LFSR_SEED;
	// Expected BSRAM contents, written by the console side and by the sector host
	logic [7:0]  console_data [BSRAM_BYTES];
	logic [7:0]  host_data [BSRAM_BYTES];
	int          sectors_served = 0;
	int          transfer_base = 0;
	int          strobe_count = 0;
	cheat_code_t strobe_code;
	// Direction of the transfer in progress, saves until the load test
	logic        load_expected = 1'b0;

	cart_top uut (.*);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], ^(state & LFSR_TAPS)};
	endfunction

	task automatic random_bits(input int count, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[14:0], lfsr[0]};
		end
	endtask

	// 1 KiB shifted by the size nibble, kept to the 24-bit mask width
	function automatic logic [23:0] size_mask(input logic [3:0] size);
		logic [23:0] one_k;
		one_k = 24'd1024;
		return (one_k << size) - 24'd1;
	endfunction

	function automatic void report_error(input string what);
		$display("%s", what);
		$display("Result: FAILED");
	endfunction

	function automatic void report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		report_error($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
			$time, name, got, exp));
	endfunction

	task automatic expect_equal(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			report_mismatch(name, got, exp);
			$fatal(1);
		end
	endtask

	// Download driver, every task starts and ends on a falling edge
	task automatic begin_download(input logic [7:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic download_word(input logic [24:0] addr, input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		repeat (2) @(negedge clk_sys);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	// Word 0 is random and must not touch the sizes of a forced map
	task automatic download_lorom();
		logic [15:0] filler;
		random_bits(16, filler);
		begin_download(8'h01);
		download_word(25'd0, filler);
		download_word(LOROM_HDR, {LOROM_ROM_SIZE, 8'h00});
		download_word(LOROM_HDR + 25'd2, {8'h00, LOROM_RAM_SIZE});
		end_download();
	endtask

	task automatic write_console(input logic [BSRAM_BITS-1:0] addr, input logic [7:0] data);
		bsram_addr = addr;
		bsram_d    = data;
		bsram_ce_n = 1'b0;
		bsram_we_n = 1'b0;
		@(negedge clk_sys);
		bsram_ce_n = 1'b1;
		bsram_we_n = 1'b1;
	endtask

	// Back-to-back calls pipeline one read per cycle
	task automatic read_console(input logic [BSRAM_BITS-1:0] addr, output logic [7:0] data);
		bsram_addr = addr;
		bsram_ce_n = 1'b0;
		bsram_we_n = 1'b1;
		@(negedge clk_sys);
		data       = bsram_q;
		bsram_ce_n = 1'b1;
	endtask

	task automatic wait_transfer_done();
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
	endtask

	// ========================================
	// Sector host model
	// ========================================
	task automatic serve_save_sector(input int base);
		logic [15:0] exp_word;
		sd_ack       = 1'b1;
		sd_buff_addr = '0;
		for (int k = 0; k < SECTOR_WORDS; k++) begin
			sd_buff_addr = 8'(k);
			@(negedge clk_sys);
			exp_word = {console_data[base + 2 * k + 1], console_data[base + 2 * k]};
			expect_equal("sd_buff_din", 128'(sd_buff_din), 128'(exp_word));
		end
		sd_ack = 1'b0;
	endtask

	task automatic serve_load_sector(input int base);
		logic [15:0] word;
		sd_ack = 1'b1;
		for (int k = 0; k < SECTOR_WORDS; k++) begin
			random_bits(16, word);
			sd_buff_addr = 8'(k);
			sd_buff_dout = word;
			sd_buff_wr   = 1'b1;
			host_data[base + 2 * k]     = word[7:0];
			host_data[base + 2 * k + 1] = word[15:8];
			@(negedge clk_sys);
		end
		sd_buff_wr = 1'b0;
		sd_ack     = 1'b0;
	endtask

	initial begin : sector_host
		logic [31:0] lba;
		logic        is_save;
		int          base;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_wr || sd_rd) begin
				lba     = sd_lba;
				is_save = sd_wr;
				expect_equal("sd_lba", 128'(lba), 128'(sectors_served - transfer_base));
				expect_equal("sd_rd", 128'(sd_rd), 128'(load_expected));
				expect_equal("sd_wr", 128'(sd_wr), 128'(!load_expected));
				base = (int'(lba) * 512) % BSRAM_BYTES;
				if (is_save)
					serve_save_sector(base);
				else
					serve_load_sector(base);
				sectors_served = sectors_served + 1;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (gg_strobe) begin
			strobe_count <= strobe_count + 1;
			strobe_code  <= gg_code;
		end
	end

	// ========================================
	// Concurrent checks
	// ========================================
	cart_dl_reset: assert property (@(posedge clk_sys) disable iff (RESET)
		(ioctl_download && ioctl_index != CODE_INDEX) |-> sys_reset)
		else begin
			report_mismatch("sys_reset", 128'(sys_reset), 128'(1'b1));
			$fatal(1);
		end

	strobe_single: assert property (@(posedge clk_sys) disable iff (RESET)
		gg_strobe |=> !gg_strobe)
		else begin
			report_mismatch("gg_strobe", 128'(gg_strobe), 128'(1'b0));
			$fatal(1);
		end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
		$fatal(1);
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin : main_sequence
		logic [15:0]           word0;
		logic [15:0]           word2;
		logic [15:0]           rnd;
		logic [BSRAM_BITS-1:0] rnd_addr;
		logic [15:0]           code_words [8];
		logic [7:0]            rd_data;
		cheat_code_t           exp_code;
		time                   t_start;
		int                    clear_cycles;

		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		header_sel     = hdr_auto;
		region_sel     = region_auto;
		autosave       = 1'b0;
		osd_open       = 1'b0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bsram_addr     = '0;
		bsram_d        = '0;
		bsram_ce_n     = 1'b1;
		bsram_we_n     = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		expect_equal("sd_rd", 128'(sd_rd), 128'(1'b0));
		expect_equal("sd_wr", 128'(sd_wr), 128'(1'b0));
		expect_equal("gg_strobe", 128'(gg_strobe), 128'(1'b0));
		expect_equal("bk_busy", 128'(bk_busy), 128'(1'b0));
		expect_equal("led_user", 128'(led_user), 128'(1'b0));

		// Cheat record from eight random words
		begin_download(CODE_INDEX);
		for (int i = 0; i < 8; i++) begin
			random_bits(16, code_words[i]);
			download_word(25'(2 * i), code_words[i]);
		end
		end_download();
		exp_code.flags   = {code_words[1], code_words[0]};
		exp_code.addr    = {code_words[3], code_words[2]};
		exp_code.compare = {code_words[5], code_words[4]};
		exp_code.replace = {code_words[7], code_words[6]};
		expect_equal("gg_strobe count", 128'(strobe_count), 128'(1));
		expect_equal("gg_code", 128'(strobe_code), 128'(exp_code));

		// Auto header, then the clear that follows it
		random_bits(16, word0);
		word0[0] = 1'b1;
		random_bits(16, word2);
		t_start = $time;
		begin_download(8'h01);
		download_word(25'd0, word0);
		download_word(25'd2, word2);
		end_download();
		expect_equal("rom_type", 128'(rom_type), 128'(word0[15:8]));
		expect_equal("rom_mask", 128'(rom_mask), 128'(size_mask(word0[3:0])));
		expect_equal("ram_mask", 128'(ram_mask),
			128'((word0[7:4] == 4'h0) ? 24'd0 : size_mask(word0[7:4])));
		while (sys_reset)
			@(negedge clk_sys);
		clear_cycles = int'(($time - t_start) / CLK_PERIOD);
		assert (clear_cycles >= BSRAM_BYTES) else begin
			report_error($sformatf("clear released sys_reset after %0d cycles, fewer than %0d",
				clear_cycles, BSRAM_BYTES));
			$fatal(1);
		end
		expect_equal("pal", 128'(pal), 128'(word2[8]));
		for (int a = 0; a < BSRAM_BYTES; a++) begin
			read_console(12'(a), rd_data);
			expect_equal("bsram_q", 128'(rd_data), 128'(ERASE_BYTE));
		end

		region_sel = region_ntsc;
		@(negedge clk_sys);
		expect_equal("pal", 128'(pal), 128'(1'b0));
		region_sel = region_pal;
		@(negedge clk_sys);
		expect_equal("pal", 128'(pal), 128'(1'b1));
		region_sel = region_auto;

		// Forced LoROM with a writable image, no automatic load yet
		header_sel  = hdr_lorom;
		img_mounted = 1'b1;
		download_lorom();
		expect_equal("rom_type", 128'(rom_type), 128'(8'h00));
		expect_equal("rom_mask", 128'(rom_mask), 128'(LOROM_ROM_MASK));
		expect_equal("ram_mask", 128'(ram_mask), 128'(LOROM_RAM_MASK));
		while (sys_reset)
			@(negedge clk_sys);

		// Manual save of random console bytes
		for (int a = 0; a < BSRAM_BYTES; a++) begin
			random_bits(8, rnd);
			console_data[a] = rnd[7:0];
			write_console(12'(a), rnd[7:0]);
		end
		transfer_base = sectors_served;
		bk_save_req   = 1'b1;
		@(negedge clk_sys);
		bk_save_req = 1'b0;
		wait_transfer_done();
		expect_equal("saved sectors", 128'(sectors_served - transfer_base), 128'(EXP_SECTORS));

		// Autosave on OSD open
		autosave = 1'b1;
		@(negedge clk_sys);
		expect_equal("led_user", 128'(led_user), 128'(1'b0));
		random_bits(12, rnd);
		rnd_addr = rnd[11:0];
		random_bits(8, rnd);
		console_data[rnd_addr] = rnd[7:0];
		write_console(rnd_addr, rnd[7:0]);
		expect_equal("led_user", 128'(led_user), 128'(1'b1));
		transfer_base = sectors_served;
		osd_open      = 1'b1;
		@(negedge clk_sys);
		expect_equal("led_user", 128'(led_user), 128'(1'b0));
		wait_transfer_done();
		expect_equal("autosaved sectors", 128'(sectors_served - transfer_base),
			128'(EXP_SECTORS));
		osd_open = 1'b0;
		autosave = 1'b0;

		// Automatic load after a download with a sized image
		img_size      = 64'(BSRAM_BYTES);
		transfer_base = sectors_served;
		load_expected = 1'b1;
		download_lorom();
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy) begin
			expect_equal("sys_reset", 128'(sys_reset), 128'(1'b1));
			@(negedge clk_sys);
		end
		expect_equal("sys_reset", 128'(sys_reset), 128'(1'b0));
		expect_equal("loaded sectors", 128'(sectors_served - transfer_base), 128'(EXP_SECTORS));
		for (int a = 0; a < BSRAM_BYTES; a++) begin
			read_console(12'(a), rd_data);
			expect_equal("bsram_q", 128'(rd_data), 128'(host_data[a]));
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* logic/cart_top.sv */
// Console side must not drive the BSRAM pins while sys_reset is high, clears take precedence
`timescale 1ns/1ps

module cart_top import cart_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        RESET,

	input  logic                        ioctl_download,
	input  logic [7:0]                  ioctl_index,
	input  logic                        ioctl_wr,
	input  logic [24:0]                 ioctl_addr,
	input  logic [15:0]                 ioctl_dout,

	input  header_sel_t                 header_sel,
	input  region_sel_t                 region_sel,
	input  logic                        autosave,
	input  logic                        osd_open,
	input  logic                        bk_load_req,
	input  logic                        bk_save_req,

	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic [63:0]                 img_size,

	output logic [31:0]                 sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	input  logic                        sd_ack,
	input  logic [SECTOR_ADDR_BITS-1:0] sd_buff_addr,
	input  logic [15:0]                 sd_buff_dout,
	input  logic                        sd_buff_wr,
	output logic [15:0]                 sd_buff_din,

	input  logic [BSRAM_BITS-1:0]       bsram_addr,
	input  logic [7:0]                  bsram_d,
	input  logic                        bsram_ce_n,
	input  logic                        bsram_we_n,
	output logic [7:0]                  bsram_q,

	output logic [7:0]                  rom_type,
	output logic [23:0]                 rom_mask,
	output logic [23:0]                 ram_mask,
	output logic                        pal,
	output cheat_code_t                 gg_code,
	output logic                        gg_strobe,
	output logic                        sys_reset,
	output logic                        bk_busy,
	output logic                        led_user
);

	logic code_download;
	logic cart_download;
	logic old_cart_download;
	logic clear_start;
	logic clearing;
	logic console_write;
	logic bk_loading;
	logic bk_pending;

	bsram_bus_if clr_bus ();
	bsram_bus_if con_bus ();
	bsram_bus_if bk_bus ();

	assign code_download = ioctl_download & (ioctl_index == CODE_INDEX);
	assign cart_download = ioctl_download & (ioctl_index != CODE_INDEX);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			old_cart_download <= 1'b0;
		else
			old_cart_download <= cart_download;
	end

	assign clear_start = cart_download & ~old_cart_download;

	// Console pins onto the shared bus
	assign con_bus.req   = ~bsram_ce_n;
	assign con_bus.op    = bsram_we_n ? mem_read : mem_write;
	assign con_bus.addr  = bsram_addr;
	assign con_bus.wdata = bsram_d;
	assign bsram_q       = con_bus.rdata;
	assign console_write = con_bus.req & con_bus.gnt & (con_bus.op == mem_write);

	assign sys_reset = RESET | cart_download | clearing | bk_loading;
	assign led_user  = cart_download | (autosave & bk_pending);

	cart_header_detect u_header (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.header_sel(header_sel), .region_sel(region_sel),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	cheat_code_assembler u_cheat (
		.clk_sys(clk_sys), .RESET(RESET), .code_download(code_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr[3:0]), .ioctl_dout(ioctl_dout),
		.gg_code(gg_code), .gg_strobe(gg_strobe)
	);

	bsram_clear u_clear (
		.clk_sys(clk_sys), .RESET(RESET), .start(clear_start),
		.clearing(clearing), .bus(clr_bus.requester)
	);

	bsram_arbiter u_arbiter (
		.clk_sys(clk_sys), .RESET(RESET),
		.clr(clr_bus.arbiter), .con(con_bus.arbiter), .bk(bk_bus.arbiter)
	);

	backup_sync u_backup (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.ram_mask(ram_mask), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.img_size(img_size), .bk_load_req(bk_load_req), .bk_save_req(bk_save_req),
		.autosave(autosave), .osd_open(osd_open), .console_write(console_write),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.sd_buff_din(sd_buff_din), .bk_busy(bk_busy), .bk_loading(bk_loading),
		.bk_pending(bk_pending), .bk(bk_bus.requester)
	);

endmodule

/* logic/backup_sync.sv */
// Moves BSRAM in 512-byte sectors from lba 0 up to ram_mask>>9, one transfer at a time
`timescale 1ns/1ps

module backup_sync import cart_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        cart_download,
	input  logic [23:0]                 ram_mask,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic [63:0]                 img_size,
	input  logic                        bk_load_req,
	input  logic                        bk_save_req,
	input  logic                        autosave,
	input  logic                        osd_open,
	input  logic                        console_write,
	input  logic                        sd_ack,
	input  logic [SECTOR_ADDR_BITS-1:0] sd_buff_addr,
	input  logic [15:0]                 sd_buff_dout,
	input  logic                        sd_buff_wr,
	output logic [31:0]                 sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic [15:0]                 sd_buff_din,
	output logic                        bk_busy,
	output logic                        bk_loading,
	output logic                        bk_pending,
	bsram_bus_if.requester              bk
);

	backup_state_t state;
	logic [15:0]   sec_buf [SECTOR_WORDS];
	logic          bk_ena;
	logic          old_download;
	logic          old_load;
	logic          old_save;
	logic          old_ack;
	logic          save_cond;
	logic          load_start;
	logic          save_start;
	logic          auto_load;
	logic          start;
	logic          ack_rise;
	logic          ack_fall;
	logic          last_sector;
	logic          sector_done;
	logic          accepted;
	// Byte index inside the sector, bit 9 marks all 512 issued
	logic [9:0]    byte_cnt;
	logic          rd_pend;
	logic [8:0]    rd_idx;
	logic [7:0]    lo_byte;
	logic [15:0]   drain_word;

	assign save_cond   = bk_save_req | (autosave & bk_pending & osd_open);
	assign load_start  = bk_load_req & bk_ena & ~old_load;
	assign save_start  = save_cond & bk_ena & ~old_save;
	assign auto_load   = old_download & ~cart_download & (|img_size) & bk_ena;
	assign start       = (state == bk_idle) & (load_start | save_start | auto_load);
	assign ack_rise    = sd_ack & ~old_ack;
	assign ack_fall    = old_ack & ~sd_ack;
	assign last_sector = sd_lba >= {17'd0, ram_mask[23:9]};
	assign bk_busy     = (state != bk_idle);
	assign sector_done = (state == bk_wait_ack && ack_fall && !bk_loading) ||
		(state == bk_drain_buffer && byte_cnt[9]);

	// Word k holds sector bytes 2k (low) and 2k+1 (high)
	assign drain_word = sec_buf[byte_cnt[8:1]];
	assign bk.req     = (state == bk_fill_buffer || state == bk_drain_buffer) && !byte_cnt[9];
	assign bk.op      = (state == bk_drain_buffer) ? mem_write : mem_read;
	assign bk.addr    = {sd_lba[BSRAM_BITS-10:0], byte_cnt[8:0]};
	assign bk.wdata   = byte_cnt[0] ? drain_word[15:8] : drain_word[7:0];
	assign accepted   = bk.req & bk.gnt;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_ack      <= 1'b0;
			bk_ena       <= 1'b0;
			bk_pending   <= 1'b0;
		end else begin
			old_download <= cart_download;
			old_load     <= bk_load_req & bk_ena;
			old_save     <= save_cond & bk_ena;
			old_ack      <= sd_ack;
			// The save image is mounted by the end of the download
			if (cart_download && !old_download)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
			if (bk_ena && !osd_open && console_write)
				bk_pending <= 1'b1;
			else if (start)
				bk_pending <= 1'b0;
		end
	end

	// ========================================
	// Sector buffer, host port while sd_ack
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (sd_ack && sd_buff_wr)
			sec_buf[sd_buff_addr] <= sd_buff_dout;
		else if (rd_pend && rd_idx[0])
			sec_buf[rd_idx[8:1]] <= {bk.rdata, lo_byte};
		if (rd_pend && !rd_idx[0])
			lo_byte <= bk.rdata;
		sd_buff_din <= sec_buf[sd_buff_addr];
	end

	// ========================================
	// Transfer FSM
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= bk_idle;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			bk_loading <= 1'b0;
			byte_cnt   <= '0;
			rd_pend    <= 1'b0;
			rd_idx     <= '0;
		end else begin
			rd_pend <= accepted && (state == bk_fill_buffer);
			if (accepted) begin
				byte_cnt <= byte_cnt + 10'd1;
				rd_idx   <= byte_cnt[8:0];
			end
			case (state)
				bk_idle: if (start) begin
					sd_lba     <= '0;
					byte_cnt   <= '0;
					bk_loading <= load_start | auto_load;
					state      <= (load_start | auto_load) ? bk_request : bk_fill_buffer;
				end
				// Wait for the last read to land in the buffer
				bk_fill_buffer: if (byte_cnt[9] && !rd_pend)
					state <= bk_request;
				bk_request: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= bk_wait_ack;
					end else begin
						sd_rd <= bk_loading;
						sd_wr <= ~bk_loading;
					end
				end
				bk_wait_ack: if (ack_fall && bk_loading) begin
					byte_cnt <= '0;
					state    <= bk_drain_buffer;
				end
				bk_drain_buffer: ;
				default: state <= bk_idle;
			endcase
			if (sector_done) begin
				byte_cnt <= '0;
				if (last_sector) begin
					bk_loading <= 1'b0;
					state      <= bk_idle;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					state  <= bk_loading ? bk_request : bk_fill_buffer;
				end
			end
		end
	end

endmodule

/* logic/bsram_arbiter.sv */
// One access per cycle, fixed priority clear > console > backup, reads return one cycle later
`timescale 1ns/1ps

module bsram_arbiter import cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	bsram_bus_if.arbiter clr,
	bsram_bus_if.arbiter con,
	bsram_bus_if.arbiter bk
);

	logic [7:0]            mem [BSRAM_BYTES];
	logic                  sel_valid;
	mem_op_t               sel_op;
	logic [BSRAM_BITS-1:0] sel_addr;
	logic [7:0]            sel_wdata;
	logic [7:0]            rd_q;
	// One-hot owner of rd_q, bit 0 clear, bit 1 console, bit 2 backup
	logic [2:0]            rd_owner;

	assign clr.gnt = clr.req;
	assign con.gnt = con.req & ~clr.req;
	assign bk.gnt  = bk.req & ~clr.req & ~con.req;

	always_comb begin
		sel_valid = clr.req | con.req | bk.req;
		if (clr.req) begin
			sel_op    = clr.op;
			sel_addr  = clr.addr;
			sel_wdata = clr.wdata;
		end else if (con.req) begin
			sel_op    = con.op;
			sel_addr  = con.addr;
			sel_wdata = con.wdata;
		end else begin
			sel_op    = bk.op;
			sel_addr  = bk.addr;
			sel_wdata = bk.wdata;
		end
	end

	// ========================================
	// Byte array
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (sel_valid && sel_op == mem_write)
			mem[sel_addr] <= sel_wdata;
		if (sel_valid && sel_op == mem_read)
			rd_q <= mem[sel_addr];
	end

	// Last reader keeps its data until another read is accepted
	always_ff @(posedge clk_sys) begin
		if (RESET)
			rd_owner <= 3'b000;
		else if (sel_valid && sel_op == mem_read)
			rd_owner <= {bk.gnt, con.gnt, clr.gnt};
	end

	assign clr.rdata = rd_owner[0] ? rd_q : 8'h00;
	assign con.rdata = rd_owner[1] ? rd_q : 8'h00;
	assign bk.rdata  = rd_owner[2] ? rd_q : 8'h00;

endmodule

/* logic/bsram_clear.sv */
// Erases every BSRAM byte once per start pulse, a new start restarts from address 0
`timescale 1ns/1ps

module bsram_clear import cart_pkg::*; (
	input  logic           clk_sys,
	input  logic           RESET,
	input  logic           start,
	output logic           clearing,
	bsram_bus_if.requester bus
);

	logic [BSRAM_BITS-1:0] fill_addr;

	assign bus.req   = clearing;
	assign bus.op    = mem_write;
	assign bus.addr  = fill_addr;
	assign bus.wdata = ERASE_BYTE;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else if (start) begin
			clearing  <= 1'b1;
			fill_addr <= '0;
		end else if (clearing && bus.gnt) begin
			fill_addr <= fill_addr + 1'b1;
			// Top address written
			if (&fill_addr)
				clearing <= 1'b0;
		end
	end

endmodule

/* logic/cheat_code_assembler.sv */
// Records arrive as eight 16-bit words at byte offsets 0..14, any other offset is ignored
`timescale 1ns/1ps

module cheat_code_assembler import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        code_download,
	input  logic        ioctl_wr,
	input  logic [3:0]  ioctl_addr,
	input  logic [15:0] ioctl_dout,
	output cheat_code_t gg_code,
	output logic        gg_strobe
);

	// Last word of a record
	always_ff @(posedge clk_sys) begin
		if (RESET)
			gg_strobe <= 1'b0;
		else
			gg_strobe <= code_download & ioctl_wr & (ioctl_addr == 4'd14);
	end

	always_ff @(posedge clk_sys) begin
		if (code_download && ioctl_wr) begin
			case (ioctl_addr)
				4'd0:  gg_code.flags[15:0]    <= ioctl_dout;
				4'd2:  gg_code.flags[31:16]   <= ioctl_dout;
				4'd4:  gg_code.addr[15:0]     <= ioctl_dout;
				4'd6:  gg_code.addr[31:16]    <= ioctl_dout;
				4'd8:  gg_code.compare[15:0]  <= ioctl_dout;
				4'd10: gg_code.compare[31:16] <= ioctl_dout;
				4'd12: gg_code.replace[15:0]  <= ioctl_dout;
				4'd14: gg_code.replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

endmodule

/* logic/cart_header_detect.sv */
// Header fields are sampled only on ioctl_wr while cart_download is high, pal follows afterwards
`timescale 1ns/1ps

module cart_header_detect import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        cart_download,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [15:0] ioctl_dout,
	input  header_sel_t header_sel,
	input  region_sel_t region_sel,
	output logic [7:0]  rom_type,
	output logic [23:0] rom_mask,
	output logic [23:0] ram_mask,
	output logic        pal
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [3:0]  rom_size_nxt;
	logic [3:0]  ram_size_nxt;
	logic [7:0]  rom_type_nxt;
	logic [24:0] size_addr;
	logic        map_forced;
	logic        hdr_region;

	// Location of the size bytes for a forced memory map
	always_comb begin
		map_forced = 1'b1;
		case (header_sel)
			hdr_lorom:   size_addr = LOROM_HDR;
			hdr_hirom:   size_addr = HIROM_HDR;
			hdr_exhirom: size_addr = EXHIROM_HDR;
			default: begin
				size_addr  = '0;
				map_forced = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (header_sel)
			hdr_auto:    rom_type_nxt = ioctl_dout[15:8];
			hdr_hirom:   rom_type_nxt = 8'd1;
			hdr_exhirom: rom_type_nxt = 8'd2;
			default:     rom_type_nxt = 8'd0;
		endcase
	end

	// Sizes after the current write, so the masks track it on the same clock
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (ioctl_addr == 25'd0) begin
			rom_size_nxt = 4'hC;
			ram_size_nxt = 4'h0;
			if (header_sel == hdr_auto && ioctl_dout[7:0] != 8'h00)
				{ram_size_nxt, rom_size_nxt} = ioctl_dout[7:0];
		end
		if (map_forced && ioctl_addr == size_addr)
			rom_size_nxt = ioctl_dout[11:8];
		if (map_forced && ioctl_addr == size_addr + 25'd2)
			ram_size_nxt = ioctl_dout[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'h0;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_mask   <= '0;
			ram_mask   <= '0;
			hdr_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				rom_size <= rom_size_nxt;
				ram_size <= ram_size_nxt;
				if (ioctl_addr == 25'd0)
					rom_type <= rom_type_nxt;
				if (ioctl_addr == 25'd2)
					hdr_region <= ioctl_dout[8];
				rom_mask <= (24'd1024 << rom_size_nxt) - 24'd1;
				ram_mask <= (ram_size_nxt != 4'h0) ? (24'd1024 << ram_size_nxt) - 24'd1 : 24'd0;
			end
		end else begin
			pal <= (region_sel == region_auto) ? hdr_region : (region_sel == region_pal);
		end
	end

endmodule

/* logic/bsram_bus_if.sv */
// Single-beat BSRAM access, requester holds its request until gnt, read data lands one cycle later
`timescale 1ns/1ps

interface bsram_bus_if import cart_pkg::*; ();

	logic                  req;
	mem_op_t               op;
	logic [BSRAM_BITS-1:0] addr;
	logic [7:0]            wdata;
	logic                  gnt;
	logic [7:0]            rdata;

	modport requester (
		output req, op, addr, wdata,
		input  gnt, rdata
	);

	modport arbiter (
		input  req, op, addr, wdata,
		output gnt, rdata
	);

endinterface

/* logic/cart_pkg.sv */
// Shared constants and types, BSRAM shrunk to 4 KiB so sectors above lba 7 alias onto it
package cart_pkg;

	// ========================================
	// Memory and sector geometry
	// ========================================
	localparam int BSRAM_BITS       = 12;
	localparam int BSRAM_BYTES      = 1 << BSRAM_BITS;
	localparam int SECTOR_WORDS     = 256;
	localparam int SECTOR_ADDR_BITS = 8;

	// Copier header in front of the image
	localparam int HEADER_SKIP = 512;

	// Word address holding the ROM size byte (high half), RAM size byte sits at +2 (low half)
	localparam logic [24:0] LOROM_HDR   = 25'h007FD6 + 25'(HEADER_SKIP);
	localparam logic [24:0] HIROM_HDR   = 25'h00FFD6 + 25'(HEADER_SKIP);
	localparam logic [24:0] EXHIROM_HDR = 25'h40FFD6 + 25'(HEADER_SKIP);

	// Download index reserved for cheat records
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	localparam logic [7:0] ERASE_BYTE = 8'hFF;

	// ========================================
	// Types
	// ========================================
	typedef enum logic [2:0] {
		hdr_auto,
		hdr_no_header,
		hdr_lorom,
		hdr_hirom,
		hdr_exhirom
	} header_sel_t;

	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} region_sel_t;

	typedef enum logic {
		mem_read,
		mem_write
	} mem_op_t;

	// Save walks fill -> request -> wait, load walks request -> wait -> drain
	typedef enum logic [2:0] {
		bk_idle,
		bk_fill_buffer,
		bk_request,
		bk_wait_ack,
		bk_drain_buffer
	} backup_state_t;

	// Each field takes its low half from the lower download offset
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage
